//--- source/joy_pkg.sv
//----------------------------------------------------------
// Shared definitions for the serial joystick front end.
// Frame constants, the vector types for slots, joystick
// words and coin lines, and the reset state encoding.
//----------------------------------------------------------

package joy_pkg;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------

  typedef logic [4:0]  slot_t;      // Slot number in a frame from 0 to 25
  typedef logic [11:0] joy_word_t;  // One player's active-low controls
  typedef logic [1:0]  coin_t;      // Active-low {player B, player A}
  typedef logic [2:0]  hold_cnt_t;  // Consecutive held frames

  // Joystick word bit positions
  // 0..5  directions and fire buttons
  // 6, 7  extra buttons
  // 8     start
  // 9     coin
  // 10    extra button
  // 11    reset on player A, reboot on player B

  // ----------------------------------------------------------
  // Frame constants
  // ----------------------------------------------------------

  localparam slot_t SLOT_LAST       = slot_t'(25);  // 26 slots per frame
  localparam slot_t SLOT_FIRST_DATA = slot_t'(2);   // Slots 0 and 1 carry no data

  // Frames with player B bit 11 low before a reboot request
  localparam hold_cnt_t REBOOT_HOLD_FRAMES = hold_cnt_t'(4);

  // ----------------------------------------------------------
  // Reset FSM states
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    RUN,           // Idle, waiting for a held reboot button
    HOLD,          // Counting held frames
    REBOOT,        // One cycle reboot pulse
    WAIT_RELEASE   // Button must be let go before the next request
  } reset_state_t;

endpackage

//--- source/joy_slot_if.sv
//----------------------------------------------------------
// Slot timing bundle between the slot timer and the blocks
// that follow the serial frame. The timer drives it, the
// deserializer samples it.
//----------------------------------------------------------

interface joy_slot_if;

  import joy_pkg::*;

  slot_t slot;       // Current slot
  logic  load_n;     // Low in slot 0 to reload the adapter
  logic  frame_end;  // High in slot 25 of a complete frame
  logic  started;    // First slot 0 has been reached

  modport timer (
    output slot,
    output load_n,
    output frame_end,
    output started
  );

  // load_n is taken out at the top level
  modport sampler (
    input slot,
    input frame_end,
    input started
  );

endinterface

//--- source/joy_slot_timer.sv
//----------------------------------------------------------
// Slot counter for the joystick frame. Wraps from 25 to 0,
// decodes the adapter load strobe in slot 0 and the frame
// end strobe in slot 25 once a full frame has run.
//----------------------------------------------------------

module joy_slot_timer (
  input  logic ena_x,
  input  logic pll_lckd,
  joy_slot_if.timer sl
);

  import joy_pkg::*;

  slot_t slot_q;
  logic  started_q;

  // ----------------------------------------------------------
  // Counter
  // ----------------------------------------------------------

  // Reset parks on the last slot so the first edge gives slot 0
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      slot_q    <= SLOT_LAST;
      started_q <= 1'b0;
    end else begin
      if (slot_q == SLOT_LAST) begin
        slot_q <= '0;
      end else begin
        slot_q <= slot_q + slot_t'(1);
      end
      started_q <= 1'b1;  // Set together with the first slot 0
    end
  end

  // ----------------------------------------------------------
  // Decodes
  // ----------------------------------------------------------

  assign sl.slot    = slot_q;
  assign sl.started = started_q;

  // Adapter reloads its shift register while low
  assign sl.load_n = (slot_q != '0);

  // Parked slot 25 after reset is not a real frame end
  assign sl.frame_end = started_q && (slot_q == SLOT_LAST);

endmodule

//--- source/joy_deserializer.sv
//----------------------------------------------------------
// Serial frame sampler. Each data slot lands in a shadow
// copy of both joystick words; at frame end the shadow is
// published in one step together with the coin pair.
//----------------------------------------------------------

module joy_deserializer (
  input  logic               ena_x,
  input  logic               pll_lckd,
  joy_slot_if.sampler        sl,
  input  logic               joy_data,
  input  logic               btn,
  output joy_pkg::joy_word_t joy_a,
  output joy_pkg::joy_word_t joy_b,
  output joy_pkg::coin_t     coin,
  output logic               frame_pub,
  output logic [1:0]         reset_pins
);

  import joy_pkg::*;

  joy_word_t shadow_a;
  joy_word_t shadow_b;
  joy_word_t shadow_a_nxt;  // Shadow including this cycle's bit
  joy_word_t shadow_b_nxt;

  // ----------------------------------------------------------
  // Slot map
  // ----------------------------------------------------------

  always_comb begin
    shadow_a_nxt = shadow_a;
    shadow_b_nxt = shadow_b;
    if (sl.started && (sl.slot >= SLOT_FIRST_DATA)) begin
      case (sl.slot)
        5'd2  : shadow_a_nxt[8]  = joy_data;  // Player A start
        5'd3  : shadow_a_nxt[6]  = joy_data;
        5'd4  : shadow_a_nxt[5]  = joy_data;
        5'd5  : shadow_a_nxt[4]  = joy_data;
        5'd6  : shadow_a_nxt[3]  = joy_data;
        5'd7  : shadow_a_nxt[2]  = joy_data;
        5'd8  : shadow_a_nxt[1]  = joy_data;
        5'd9  : shadow_a_nxt[0]  = joy_data;
        5'd10 : shadow_b_nxt[8]  = joy_data;  // Player B start
        5'd11 : shadow_b_nxt[6]  = joy_data;
        5'd12 : shadow_b_nxt[5]  = joy_data;
        5'd13 : shadow_b_nxt[4]  = joy_data;
        5'd14 : shadow_b_nxt[3]  = joy_data;
        5'd15 : shadow_b_nxt[2]  = joy_data;
        5'd16 : shadow_b_nxt[1]  = joy_data;
        5'd17 : shadow_b_nxt[0]  = joy_data;
        // Upper buttons come after both direction groups
        5'd18 : shadow_b_nxt[10] = joy_data;
        5'd19 : shadow_b_nxt[11] = joy_data;  // Reboot button
        5'd20 : shadow_b_nxt[9]  = joy_data;
        5'd21 : shadow_b_nxt[7]  = joy_data;
        5'd22 : shadow_a_nxt[10] = joy_data;
        5'd23 : shadow_a_nxt[11] = joy_data;  // Reset button
        5'd24 : shadow_a_nxt[9]  = joy_data;
        5'd25 : shadow_a_nxt[7]  = joy_data;
        default : ;
      endcase
    end
  end

  // Shadow words take one bit per data slot
  always_ff @(posedge ena_x) begin
    shadow_a <= shadow_a_nxt;
    shadow_b <= shadow_b_nxt;
  end

  // ----------------------------------------------------------
  // Publication
  // ----------------------------------------------------------

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      joy_a     <= '1;
      joy_b     <= '1;
      coin      <= '1;
      frame_pub <= 1'b0;
    end else begin
      frame_pub <= sl.frame_end;
      if (sl.frame_end) begin
        joy_a <= shadow_a_nxt;  // Last bit of the frame goes straight through
        joy_b <= shadow_b_nxt;
        // Cabinet button doubles as player A coin
        coin  <= {shadow_b_nxt[9], shadow_a_nxt[9] & btn};
      end
    end
  end

  assign reset_pins = {joy_b[11], joy_a[11]};

endmodule

//--- source/joy_reset_fsm.sv
//----------------------------------------------------------
// Reset control from the published joystick words. Makes
// the arcade reset level from player A bit 11 or the reset
// key, and one reboot pulse when player B bit 11 is held.
//----------------------------------------------------------

module joy_reset_fsm (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       frame_pub,
  input  logic [1:0] reset_pins,
  input  logic       reset_key,
  output logic       machine_reset,
  output logic       reboot
);

  import joy_pkg::*;

  reset_state_t state;
  reset_state_t state_nxt;
  hold_cnt_t    hold_cnt;
  hold_cnt_t    hold_cnt_nxt;
  logic         b_held;      // Published player B reboot button pressed
  logic         b_released;

  assign b_held     = frame_pub && !reset_pins[1];
  assign b_released = frame_pub && reset_pins[1];

  // ----------------------------------------------------------
  // Machine reset level
  // ----------------------------------------------------------

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      machine_reset <= 1'b0;
    end else begin
      machine_reset <= reset_key | ~reset_pins[0];
    end
  end

  // ----------------------------------------------------------
  // Reboot request
  // ----------------------------------------------------------

  always_comb begin
    state_nxt    = state;
    hold_cnt_nxt = hold_cnt;
    case (state)
      RUN: begin
        if (b_held) begin
          state_nxt    = HOLD;
          hold_cnt_nxt = hold_cnt_t'(1);
        end
      end
      HOLD: begin
        if (b_released) begin
          state_nxt    = RUN;  // Let go too early
          hold_cnt_nxt = '0;
        end else if (b_held) begin
          hold_cnt_nxt = hold_cnt + hold_cnt_t'(1);
          if (hold_cnt_nxt == REBOOT_HOLD_FRAMES) begin
            state_nxt = REBOOT;
          end
        end
      end
      REBOOT: begin
        state_nxt    = WAIT_RELEASE;  // Single cycle only
        hold_cnt_nxt = '0;
      end
      WAIT_RELEASE: begin
        if (b_released) begin
          state_nxt = RUN;
        end
      end
      default: begin
        state_nxt    = RUN;
        hold_cnt_nxt = '0;
      end
    endcase
  end

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      state    <= RUN;
      hold_cnt <= '0;
    end else begin
      state    <= state_nxt;
      hold_cnt <= hold_cnt_nxt;
    end
  end

  assign reboot = (state == REBOOT);

endmodule

//--- source/joy_input_top.sv
//----------------------------------------------------------
// Joystick front end top level. Ties the slot timer, the
// frame deserializer and the reset FSM together and brings
// the adapter load strobe and joystick words out.
//----------------------------------------------------------

module joy_input_top (
  input  logic               ena_x,
  input  logic               pll_lckd,
  input  logic               joy_data,    // Serial data from the adapter
  input  logic               btn,         // Board button for an extra coin
  input  logic               reset_key,   // From the keyboard
  output logic               joy_load_n,  // Adapter reload strobe
  output joy_pkg::joy_word_t joy_a,
  output joy_pkg::joy_word_t joy_b,
  output joy_pkg::coin_t     coin,
  output logic               machine_reset,
  output logic               reboot
);

  logic       frame_pub;
  logic [1:0] reset_pins;

  // ----------------------------------------------------------
  // Slot timing
  // ----------------------------------------------------------

  joy_slot_if slot_bus ();

  joy_slot_timer i_joy_slot_timer (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .sl       (slot_bus.timer)
  );

  assign joy_load_n = slot_bus.load_n;

  // ----------------------------------------------------------
  // Frame capture
  // ----------------------------------------------------------

  joy_deserializer i_joy_deserializer (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .sl         (slot_bus.sampler),
    .joy_data   (joy_data),
    .btn        (btn),
    .joy_a      (joy_a),
    .joy_b      (joy_b),
    .coin       (coin),
    .frame_pub  (frame_pub),
    .reset_pins (reset_pins)
  );

  // ----------------------------------------------------------
  // Reset control
  // ----------------------------------------------------------

  joy_reset_fsm i_joy_reset_fsm (
    .ena_x         (ena_x),
    .pll_lckd      (pll_lckd),
    .frame_pub     (frame_pub),
    .reset_pins    (reset_pins),
    .reset_key     (reset_key),
    .machine_reset (machine_reset),
    .reboot        (reboot)
  );

endmodule

//--- testbench/tb_joy_pad_model.sv
//----------------------------------------------------------
// Behavioral model of the shift-register joystick adapter.
// Reloads a 24-bit frame while joy_load_n is low and then
// presents one bit per slot on joy_data.
//----------------------------------------------------------

module tb_joy_pad_model (
  input  logic        ena_x,
  input  logic        load_n,
  input  logic [23:0] pattern,   // Bit k goes out in slot k + 2
  output logic        joy_data
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FIRST_DATA = 2;
  localparam int LAST_SLOT  = 25;

  logic [23:0] frame_q;
  int unsigned pos;  // Slot the adapter is about to present

  initial begin
    frame_q  = '1;
    pos      = 0;
    joy_data = 1'b1;
  end

  // ----------------------------------------------------------
  // Reload and advance
  // ----------------------------------------------------------

  always @(posedge ena_x) begin
    if (!load_n) begin
      frame_q <= pattern;
      pos     <= 1;      // Slot 1 comes next
    end else if (pos <= LAST_SLOT) begin
      pos <= pos + 1;
    end
  end

  // Output changes away from the sampling edge
  always @(negedge ena_x) begin
    if ((pos >= FIRST_DATA) && (pos <= LAST_SLOT)) begin
      joy_data <= frame_q[pos - FIRST_DATA];
    end else begin
      joy_data <= 1'b1;  // Idle slots read as released
    end
  end

endmodule

//--- testbench/tb_joy_input_top.sv
//----------------------------------------------------------
// Testbench for the joystick front end. Drives random frames
// through the adapter model and checks published words, coin,
// machine reset and reboot against a reference of the frame.
//----------------------------------------------------------

module tb_joy_input_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int FRAME_SLOTS  = 26;
  localparam int MAX_FRAMES   = 40;
  localparam int HOLD_FRAMES  = 4;
  localparam logic [23:0] B11_MASK = 24'h020000;  // Slot 19
  localparam logic [23:0] A11_MASK = 24'h200000;  // Slot 23
  localparam logic [23:0] BOTH_11  = A11_MASK | B11_MASK;

  logic        ena_x;
  logic        pll_lckd;
  logic        joy_data;
  logic        btn;
  logic        reset_key;
  logic        joy_load_n;
  logic [11:0] joy_a;
  logic [11:0] joy_b;
  logic [1:0]  coin;
  logic        machine_reset;
  logic        reboot;

  logic [23:0] pad_pattern;
  integer      seed;

  // Reference of the frame timing and expected outputs
  int unsigned edge_cnt  = 0;
  logic [23:0] frame_pat = '1;
  logic        btn_pub   = 1'b1;
  logic        exp_mr    = 1'b0;
  logic [11:0] exp_a     = '1;
  logic [11:0] exp_b     = '1;
  logic [1:0]  exp_coin;
  logic        exp_load_n;
  logic        exp_reboot;
  logic        pulse_due = 1'b0;
  int          held_cnt  = 0;
  int          reboot_count = 0;

  joy_input_top i_joy_input_top (
    .ena_x         (ena_x),
    .pll_lckd      (pll_lckd),
    .joy_data      (joy_data),
    .btn           (btn),
    .reset_key     (reset_key),
    .joy_load_n    (joy_load_n),
    .joy_a         (joy_a),
    .joy_b         (joy_b),
    .coin          (coin),
    .machine_reset (machine_reset),
    .reboot        (reboot)
  );

  tb_joy_pad_model i_pad_model (
    .ena_x    (ena_x),
    .load_n   (joy_load_n),
    .pattern  (pad_pattern),
    .joy_data (joy_data)
  );

  initial begin
    ena_x = 1'b0;
    forever #(CLK_PERIOD / 2) ena_x = ~ena_x;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [11:0] exp_v,
                                 input logic [11:0] act_v);
    stop_on_error($sformatf("mismatch at time %0t: %s expected %h, actual %h",
                            $time, name, exp_v, act_v));
  endtask

  // Current slot after the given number of edges
  function automatic int unsigned slot_of(input int unsigned edges);
    if (edges == 0) begin
      return 25;
    end
    return (edges - 1) % FRAME_SLOTS;
  endfunction

  // Applies the slot map to one player's eight low and four upper bits
  function automatic logic [11:0] decode_word(input logic [7:0] low_grp,
                                              input logic [3:0] high_grp);
    logic [11:0] w;
    w[8]  = low_grp[0];
    w[6]  = low_grp[1];
    w[5]  = low_grp[2];
    w[4]  = low_grp[3];
    w[3]  = low_grp[4];
    w[2]  = low_grp[5];
    w[1]  = low_grp[6];
    w[0]  = low_grp[7];
    w[10] = high_grp[0];
    w[11] = high_grp[1];
    w[9]  = high_grp[2];
    w[7]  = high_grp[3];
    return w;
  endfunction

  task automatic wait_frame_start();
    @(negedge ena_x);
    while (joy_load_n !== 1'b0) @(negedge ena_x);
  endtask

  // Random frame with the bits under keep_mask taken from keep_val
  task automatic send_frame(input logic [23:0] keep_mask, input logic [23:0] keep_val,
                            input logic btn_level);
    logic [23:0] pat;
    pat = $random(seed);
    pat = (pat & ~keep_mask) | (keep_val & keep_mask);
    wait_frame_start();
    pad_pattern = pat;
    btn         = btn_level;
  endtask

  task automatic hold_reboot(input int frames);
    repeat (frames) send_frame(BOTH_11, A11_MASK, 1'b1);
    send_frame(BOTH_11, BOTH_11, 1'b1);  // Release frame
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  always @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      edge_cnt  <= 0;
      frame_pat <= '1;
      btn_pub   <= 1'b1;
      exp_mr    <= 1'b0;
    end else begin
      if ((edge_cnt != 0) && (slot_of(edge_cnt) == 0)) frame_pat <= pad_pattern;
      if ((edge_cnt != 0) && (slot_of(edge_cnt) == 25)) btn_pub <= btn;  // Frame end
      exp_mr   <= reset_key | ~exp_a[11];
      edge_cnt <= edge_cnt + 1;
    end
  end

  // Every output checked on every falling edge
  always @(negedge ena_x) begin
    if (!pll_lckd) begin
      exp_a     = '1;
      exp_b     = '1;
      held_cnt  = 0;
      pulse_due = 1'b0;
    end else if ((edge_cnt > FRAME_SLOTS) && (slot_of(edge_cnt) == 0)) begin
      exp_a     = decode_word(frame_pat[7:0], frame_pat[23:20]);
      exp_b     = decode_word(frame_pat[15:8], frame_pat[19:16]);
      held_cnt  = exp_b[11] ? 0 : held_cnt + 1;
      pulse_due = (held_cnt == HOLD_FRAMES);
    end
    exp_load_n = !((edge_cnt != 0) && (slot_of(edge_cnt) == 0));
    exp_coin   = {exp_b[9], exp_a[9] & btn_pub};
    exp_reboot = pulse_due && (edge_cnt != 0) && (slot_of(edge_cnt) == 1);

    assert (joy_load_n === exp_load_n)
      else report_mismatch("joy_load_n", {11'b0, exp_load_n}, {11'b0, joy_load_n});
    assert (joy_a === exp_a) else report_mismatch("joy_a", exp_a, joy_a);
    assert (joy_b === exp_b) else report_mismatch("joy_b", exp_b, joy_b);
    assert (coin === exp_coin) else report_mismatch("coin", {10'b0, exp_coin}, {10'b0, coin});
    assert (machine_reset === exp_mr)
      else report_mismatch("machine_reset", {11'b0, exp_mr}, {11'b0, machine_reset});
    assert (reboot === exp_reboot)
      else report_mismatch("reboot", {11'b0, exp_reboot}, {11'b0, reboot});
    if (reboot === 1'b1) reboot_count++;
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  initial begin
    seed        = 32'h7ec2;
    pll_lckd    = 1'b0;
    btn         = 1'b1;
    reset_key   = 1'b0;
    pad_pattern = '1;
    repeat (RESET_CYCLES) @(negedge ena_x);
    pll_lckd = 1'b1;

    for (int i = 0; i < 8; i++) begin
      send_frame(B11_MASK, B11_MASK, i[0]);  // A11 and btn both vary
    end

    // Reset key alone once a frame with A11 released is published
    send_frame(BOTH_11, BOTH_11, 1'b1);
    send_frame(BOTH_11, BOTH_11, 1'b1);
    repeat (8) @(negedge ena_x);
    reset_key = 1'b1;
    repeat (5) @(negedge ena_x);
    reset_key = 1'b0;

    send_frame(BOTH_11, B11_MASK, 1'b0);  // A11 pressed
    send_frame(BOTH_11, BOTH_11, 1'b1);

    hold_reboot(3);                      // Too short
    hold_reboot(HOLD_FRAMES + 1);        // One pulse only
    hold_reboot(HOLD_FRAMES);

    // Let the last frame publish
    wait_frame_start();
    repeat (4) @(negedge ena_x);
    @(posedge ena_x);
    if (reboot_count == 2) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_on_error($sformatf("expected 2 reboot pulses, saw %0d", reboot_count));
    end
  end

  // Frame budget plus reset
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + MAX_FRAMES * FRAME_SLOTS));
    stop_on_error("timeout, the test did not finish within the frame budget");
  end

endmodule

//--- joy_input_top.f
source/joy_pkg.sv
source/joy_slot_if.sv
source/joy_slot_timer.sv
source/joy_deserializer.sv
source/joy_reset_fsm.sv
source/joy_input_top.sv
testbench/tb_joy_pad_model.sv
testbench/tb_joy_input_top.sv
